// ==== common/gat_defines.svh ====
`ifndef GAT_DEFINES_SVH
`define GAT_DEFINES_SVH

// one feature element or one weight
`define GAT_FEAT_W       8
`define GAT_NUM_FEAT     4
`define GAT_WIDX_W       2

// dot product of four 8x8 products fits with margin
`define GAT_SCORE_W      20

// feature memory geometry, one 32-bit node sum per word
`define GAT_ADDR_W       6
`define GAT_MEM_DEPTH    64
`define GAT_DATA_W       32

// node addresses from here upward are reserved
`define GAT_ADDR_LIMIT   48
`define GAT_CAPTURE_NODE 10

// negative scores are scaled by 1/8
`define GAT_LEAK_SHIFT   3

`endif

// ==== common/gat_pkg.sv ====
`include "gat_defines.svh"

package gat_pkg;

  // signed feature element and weight
  typedef logic signed [`GAT_FEAT_W-1:0] feat_t;

  // all feature elements of one edge, element 0 in the low byte
  typedef feat_t [`GAT_NUM_FEAT-1:0] feat_vec_t;

  // signed edge score as produced by the dot product
  typedef logic signed [`GAT_SCORE_W-1:0] score_t;

  // aggregator FSM
  typedef enum logic {
    AGG_IDLE,
    AGG_ACCUM
  } agg_state_e;

endpackage

// ==== debug/gat_debugger.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module gat_debugger (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dmvm_vld_i,
  input  logic                   sm_vld_i,
  input  logic                   aggr_we_i,
  input  gat_pkg::score_t        score_i,
  input  logic [`GAT_ADDR_W-1:0] node_addr_i,
  input  logic [`GAT_ADDR_W-1:0] feat_addr_i,
  output logic [`GAT_DATA_W-1:0] debug_flags_o,
  output logic [`GAT_DATA_W-1:0] debug_count_o,
  output logic [`GAT_DATA_W-1:0] debug_capture_o
);

  logic dmvm_seen;
  logic dmvm_seen_reg;
  logic sm_seen;
  logic sm_seen_reg;
  logic aggr_seen;
  logic aggr_seen_reg;
  logic addr_hit;
  logic addr_flag;
  logic addr_flag_reg;

  // each flag sets on its strobe and then holds until reset
  assign dmvm_seen = dmvm_vld_i ? 1'b1 : dmvm_seen_reg;
  assign sm_seen   = sm_vld_i   ? 1'b1 : sm_seen_reg;
  assign aggr_seen = aggr_we_i  ? 1'b1 : aggr_seen_reg;

  // a write into the reserved part of the feature memory
  assign addr_hit  = aggr_we_i && (feat_addr_i >= `GAT_ADDR_W'(`GAT_ADDR_LIMIT));
  assign addr_flag = addr_hit ? 1'b1 : addr_flag_reg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dmvm_seen_reg <= 1'b0;
      sm_seen_reg   <= 1'b0;
      aggr_seen_reg <= 1'b0;
      addr_flag_reg <= 1'b0;
    end else begin
      dmvm_seen_reg <= dmvm_seen;
      sm_seen_reg   <= sm_seen;
      aggr_seen_reg <= aggr_seen;
      addr_flag_reg <= addr_flag;
    end
  end

  logic                   capture_hit;
  logic [`GAT_DATA_W-1:0] score_ext;
  logic [`GAT_DATA_W-1:0] counter;
  logic [`GAT_DATA_W-1:0] counter_reg;
  logic [`GAT_DATA_W-1:0] capture;
  logic [`GAT_DATA_W-1:0] capture_reg;

  assign capture_hit = dmvm_vld_i && (node_addr_i == `GAT_ADDR_W'(`GAT_CAPTURE_NODE));
  assign score_ext   = {{(`GAT_DATA_W-`GAT_SCORE_W){score_i[`GAT_SCORE_W-1]}}, score_i};

  // counts activated edges, one per sm strobe
  assign counter = sm_vld_i ? (counter_reg + 1'b1) : counter_reg;

  // later edges of the capture node overwrite earlier ones
  assign capture = capture_hit ? score_ext : capture_reg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      counter_reg <= '0;
      capture_reg <= '0;
    end else begin
      counter_reg <= counter;
      capture_reg <= capture;
    end
  end

  assign debug_flags_o = {
    {(`GAT_DATA_W-4){1'b0}},
    addr_flag_reg,
    aggr_seen_reg,
    sm_seen_reg,
    dmvm_seen_reg
  };

  assign debug_count_o   = counter_reg;
  assign debug_capture_o = capture_reg;

endmodule

// ==== files.f ====
+incdir+common
common/gat_pkg.sv
source/dmvm_stage.sv
source/score_activation.sv
source/aggregator.sv
source/feat_bram.sv
debug/gat_debugger.sv
source/gat_layer_top.sv
verification/gat_checker.sv
verification/tb_gat_layer.sv

// ==== source/aggregator.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module aggregator (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   sm_vld_i,
  input  gat_pkg::score_t        act_score_i,
  input  logic [`GAT_ADDR_W-1:0] node_addr_i,
  input  logic                   edge_last_i,
  output logic                   feat_we_o,
  output logic [`GAT_ADDR_W-1:0] feat_addr_o,
  output logic [`GAT_DATA_W-1:0] feat_din_o
);

  gat_pkg::agg_state_e           state_q;
  gat_pkg::agg_state_e           state_d;
  logic signed [`GAT_DATA_W-1:0] sum_q;
  logic signed [`GAT_DATA_W-1:0] sum_d;
  logic signed [`GAT_DATA_W-1:0] sum_base;
  logic signed [`GAT_DATA_W-1:0] act_ext;
  logic signed [`GAT_DATA_W-1:0] sum_total;

  assign act_ext = {{(`GAT_DATA_W-`GAT_SCORE_W){act_score_i[`GAT_SCORE_W-1]}}, act_score_i};

  // the first edge of a node starts a fresh sum
  assign sum_base  = (state_q == gat_pkg::AGG_IDLE) ? '0 : sum_q;
  assign sum_total = sum_base + act_ext;

  always_comb begin
    state_d = state_q;
    sum_d   = sum_q;
    if (sm_vld_i) begin
      if (edge_last_i) begin
        // node closes here, the total goes out on the write port next cycle
        state_d = gat_pkg::AGG_IDLE;
        sum_d   = '0;
      end else begin
        state_d = gat_pkg::AGG_ACCUM;
        sum_d   = sum_total;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= gat_pkg::AGG_IDLE;
      sum_q     <= '0;
      feat_we_o <= 1'b0;
    end else begin
      state_q   <= state_d;
      sum_q     <= sum_d;
      feat_we_o <= sm_vld_i && edge_last_i;
    end
  end

  always_ff @(posedge clk) begin
    if (sm_vld_i && edge_last_i) begin
      feat_addr_o <= node_addr_i;
      feat_din_o  <= sum_total;
    end
  end

endmodule

// ==== source/dmvm_stage.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module dmvm_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wgt_wr_i,
  input  logic [`GAT_WIDX_W-1:0] wgt_idx_i,
  input  gat_pkg::feat_t         wgt_data_i,
  input  logic                   edge_vld_i,
  input  gat_pkg::feat_vec_t     edge_feat_i,
  input  logic [`GAT_ADDR_W-1:0] node_addr_i,
  input  logic                   edge_last_i,
  output logic                   dmvm_vld_o,
  output gat_pkg::score_t        score_o,
  output logic [`GAT_ADDR_W-1:0] node_addr_o,
  output logic                   edge_last_o
);

  gat_pkg::feat_t  wgt_q [`GAT_NUM_FEAT];
  gat_pkg::score_t dot;

  // weights are only written while the edge stream is idle
  always_ff @(posedge clk) begin
    if (wgt_wr_i) begin
      wgt_q[wgt_idx_i] <= wgt_data_i;
    end
  end

  // each product is sign extended to the score width before summing
  always_comb begin
    dot = '0;
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      dot = dot + gat_pkg::score_t'($signed(edge_feat_i[k]))
                * gat_pkg::score_t'($signed(wgt_q[k]));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dmvm_vld_o <= 1'b0;
    end else begin
      dmvm_vld_o <= edge_vld_i;
    end
  end

  // node address and last flag ride along with the score
  always_ff @(posedge clk) begin
    if (edge_vld_i) begin
      score_o     <= dot;
      node_addr_o <= node_addr_i;
      edge_last_o <= edge_last_i;
    end
  end

endmodule

// ==== source/feat_bram.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module feat_bram (
  input  logic                   clk,
  input  logic                   we_i,
  input  logic [`GAT_ADDR_W-1:0] waddr_i,
  input  logic [`GAT_DATA_W-1:0] din_i,
  input  logic [`GAT_ADDR_W-1:0] raddr_i,
  output logic [`GAT_DATA_W-1:0] dout_o
);

  logic [`GAT_DATA_W-1:0] mem [`GAT_MEM_DEPTH];

  // write port, driven by the aggregator
  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[waddr_i] <= din_i;
    end
  end

  // read data shows up one cycle after the address
  always_ff @(posedge clk) begin
    dout_o <= mem[raddr_i];
  end

endmodule

// ==== source/gat_layer_top.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module gat_layer_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wgt_wr_i,
  input  logic [`GAT_WIDX_W-1:0] wgt_idx_i,
  input  gat_pkg::feat_t         wgt_data_i,
  input  logic                   edge_vld_i,
  input  gat_pkg::feat_vec_t     edge_feat_i,
  input  logic [`GAT_ADDR_W-1:0] node_addr_i,
  input  logic                   edge_last_i,
  input  logic [`GAT_ADDR_W-1:0] rd_addr_i,
  output logic [`GAT_DATA_W-1:0] rd_data_o,
  output logic [`GAT_DATA_W-1:0] debug_flags_o,
  output logic [`GAT_DATA_W-1:0] debug_count_o,
  output logic [`GAT_DATA_W-1:0] debug_capture_o
);

  // dot product stage outputs
  logic                   dmvm_vld;
  gat_pkg::score_t        dmvm_score;
  logic [`GAT_ADDR_W-1:0] dmvm_addr;
  logic                   dmvm_last;

  // activation stage outputs
  logic                   sm_vld;
  gat_pkg::score_t        act_score;
  logic [`GAT_ADDR_W-1:0] sm_addr;
  logic                   sm_last;

  // aggregator write port
  logic                   feat_we;
  logic [`GAT_ADDR_W-1:0] feat_addr;
  logic [`GAT_DATA_W-1:0] feat_din;

  dmvm_stage i_dmvm_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .wgt_wr_i    (wgt_wr_i),
    .wgt_idx_i   (wgt_idx_i),
    .wgt_data_i  (wgt_data_i),
    .edge_vld_i  (edge_vld_i),
    .edge_feat_i (edge_feat_i),
    .node_addr_i (node_addr_i),
    .edge_last_i (edge_last_i),
    .dmvm_vld_o  (dmvm_vld),
    .score_o     (dmvm_score),
    .node_addr_o (dmvm_addr),
    .edge_last_o (dmvm_last)
  );

  score_activation i_score_activation (
    .clk         (clk),
    .rst_n       (rst_n),
    .dmvm_vld_i  (dmvm_vld),
    .score_i     (dmvm_score),
    .node_addr_i (dmvm_addr),
    .edge_last_i (dmvm_last),
    .sm_vld_o    (sm_vld),
    .act_score_o (act_score),
    .node_addr_o (sm_addr),
    .edge_last_o (sm_last)
  );

  aggregator i_aggregator (
    .clk         (clk),
    .rst_n       (rst_n),
    .sm_vld_i    (sm_vld),
    .act_score_i (act_score),
    .node_addr_i (sm_addr),
    .edge_last_i (sm_last),
    .feat_we_o   (feat_we),
    .feat_addr_o (feat_addr),
    .feat_din_o  (feat_din)
  );

  feat_bram i_feat_bram (
    .clk     (clk),
    .we_i    (feat_we),
    .waddr_i (feat_addr),
    .din_i   (feat_din),
    .raddr_i (rd_addr_i),
    .dout_o  (rd_data_o)
  );

  // the observer sees the raw score, before the rectifier
  gat_debugger i_gat_debugger (
    .clk             (clk),
    .rst_n           (rst_n),
    .dmvm_vld_i      (dmvm_vld),
    .sm_vld_i        (sm_vld),
    .aggr_we_i       (feat_we),
    .score_i         (dmvm_score),
    .node_addr_i     (dmvm_addr),
    .feat_addr_i     (feat_addr),
    .debug_flags_o   (debug_flags_o),
    .debug_count_o   (debug_count_o),
    .debug_capture_o (debug_capture_o)
  );

endmodule

// ==== source/score_activation.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module score_activation (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dmvm_vld_i,
  input  gat_pkg::score_t        score_i,
  input  logic [`GAT_ADDR_W-1:0] node_addr_i,
  input  logic                   edge_last_i,
  output logic                   sm_vld_o,
  output gat_pkg::score_t        act_score_o,
  output logic [`GAT_ADDR_W-1:0] node_addr_o,
  output logic                   edge_last_o
);

  gat_pkg::score_t act;

  // leaky rectifier, the shift keeps the sign of a negative score
  assign act = score_i[`GAT_SCORE_W-1] ? (score_i >>> `GAT_LEAK_SHIFT) : score_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_vld_o <= 1'b0;
    end else begin
      sm_vld_o <= dmvm_vld_i;
    end
  end

  always_ff @(posedge clk) begin
    if (dmvm_vld_i) begin
      act_score_o <= act;
      node_addr_o <= node_addr_i;
      edge_last_o <= edge_last_i;
    end
  end

endmodule

// ==== verification/gat_checker.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module gat_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   wgt_wr_i,
  input  logic [`GAT_WIDX_W-1:0] wgt_idx_i,
  input  gat_pkg::feat_t         wgt_data_i,
  input  logic                   edge_vld_i,
  input  gat_pkg::feat_vec_t     edge_feat_i,
  input  logic [`GAT_ADDR_W-1:0] node_addr_i,
  input  logic                   edge_last_i,
  input  logic [`GAT_ADDR_W-1:0] rd_addr_i,
  input  logic [`GAT_DATA_W-1:0] rd_data_i,
  input  logic [`GAT_DATA_W-1:0] debug_flags_i,
  input  logic [`GAT_DATA_W-1:0] debug_count_i,
  input  logic [`GAT_DATA_W-1:0] debug_capture_i,
  input  logic                   rd_chk_i,
  input  logic                   dbg_chk_i,
  output int                     error_count_o
);

  int                     wgt_m [`GAT_NUM_FEAT];
  int                     mem_m [`GAT_MEM_DEPTH];
  bit                     mem_ok [`GAT_MEM_DEPTH];
  int                     sum_m;
  int                     count_m;
  int                     capture_m;
  logic [3:0]             flags_m;
  int                     edge_score;
  int                     edge_act;
  logic                   rd_pending;
  logic [`GAT_ADDR_W-1:0] rd_addr_q;
  int                     errors;

  // negative scores are divided by 8, rounding toward minus infinity
  function automatic int leaky_relu(input int score);
    if (score < 0) begin
      return score >>> `GAT_LEAK_SHIFT;
    end
    return score;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_m      = 0;
      count_m    = 0;
      capture_m  = 0;
      flags_m    = '0;
      rd_pending = 1'b0;
      for (int a = 0; a < `GAT_MEM_DEPTH; a++) begin
        mem_ok[a] = 1'b0;
      end
    end else begin
      rd_pending = rd_chk_i;
      rd_addr_q  = rd_addr_i;
      if (wgt_wr_i) begin
        wgt_m[wgt_idx_i] = int'($signed(wgt_data_i));
      end
      if (edge_vld_i) begin
        edge_score = 0;
        for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
          edge_score += int'($signed(edge_feat_i[k])) * wgt_m[k];
        end
        edge_act   = leaky_relu(edge_score);
        sum_m     += edge_act;
        count_m++;
        flags_m[1:0] = 2'b11;
        if (node_addr_i == `GAT_CAPTURE_NODE) begin
          capture_m = edge_score;
        end
        if (edge_last_i) begin
          mem_m[node_addr_i]  = sum_m;
          mem_ok[node_addr_i] = 1'b1;
          sum_m      = 0;
          flags_m[2] = 1'b1;
          if (node_addr_i >= `GAT_ADDR_LIMIT) begin
            flags_m[3] = 1'b1;
          end
        end
      end
    end
  end

  // outputs are compared half a cycle after the edge that updates them
  always @(negedge clk) begin
    if (rst_n && rd_pending) begin
      if (!mem_ok[rd_addr_q]) begin
        $display("node %0d was read back but the model never wrote it", rd_addr_q);
        errors++;
      end else if ($signed(rd_data_i) !== mem_m[rd_addr_q]) begin
        $display("Mismatch at %0t: node %0d sum is %0d, expected %0d",
                 $time, rd_addr_q, $signed(rd_data_i), mem_m[rd_addr_q]);
        errors++;
      end
    end
    if (rst_n && dbg_chk_i) begin
      if (debug_flags_i !== {28'd0, flags_m}) begin
        $display("Mismatch at %0t: debug flags are %h, expected %h",
                 $time, debug_flags_i, flags_m);
        errors++;
      end
      if (debug_count_i !== count_m) begin
        $display("Mismatch at %0t: debug count is %0d, expected %0d",
                 $time, debug_count_i, count_m);
        errors++;
      end
      if ($signed(debug_capture_i) !== capture_m) begin
        $display("Mismatch at %0t: captured score is %0d, expected %0d",
                 $time, $signed(debug_capture_i), capture_m);
        errors++;
      end
    end
  end

  initial begin
    errors = 0;
  end

  assign error_count_o = errors;

endmodule

// ==== verification/tb_gat_layer.sv ====
`timescale 1ns/1ps
`include "gat_defines.svh"

module tb_gat_layer;

  localparam int DRAIN_LIMIT = 64;

  logic                   clk;
  logic                   rst_n;
  logic                   wgt_wr;
  logic [`GAT_WIDX_W-1:0] wgt_idx;
  gat_pkg::feat_t         wgt_data;
  logic                   edge_vld;
  gat_pkg::feat_vec_t     edge_feat;
  logic [`GAT_ADDR_W-1:0] node_addr;
  logic                   edge_last;
  logic [`GAT_ADDR_W-1:0] rd_addr;
  logic [`GAT_DATA_W-1:0] rd_data;
  logic [`GAT_DATA_W-1:0] debug_flags;
  logic [`GAT_DATA_W-1:0] debug_count;
  logic [`GAT_DATA_W-1:0] debug_capture;
  logic                   rd_chk;
  logic                   dbg_chk;
  int                     err_cnt;

  logic [31:0]            rng_state;
  bit                     timed_out;
  int                     sent_edges;
  int                     tests_run;
  int                     tests_failed;
  int                     err_before;
  logic [`GAT_ADDR_W-1:0] read_list [$];

  always #2 clk = ~clk;

  gat_layer_top i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_wr_i        (wgt_wr),
    .wgt_idx_i       (wgt_idx),
    .wgt_data_i      (wgt_data),
    .edge_vld_i      (edge_vld),
    .edge_feat_i     (edge_feat),
    .node_addr_i     (node_addr),
    .edge_last_i     (edge_last),
    .rd_addr_i       (rd_addr),
    .rd_data_o       (rd_data),
    .debug_flags_o   (debug_flags),
    .debug_count_o   (debug_count),
    .debug_capture_o (debug_capture)
  );

  gat_checker i_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .wgt_wr_i        (wgt_wr),
    .wgt_idx_i       (wgt_idx),
    .wgt_data_i      (wgt_data),
    .edge_vld_i      (edge_vld),
    .edge_feat_i     (edge_feat),
    .node_addr_i     (node_addr),
    .edge_last_i     (edge_last),
    .rd_addr_i       (rd_addr),
    .rd_data_i       (rd_data),
    .debug_flags_i   (debug_flags),
    .debug_count_i   (debug_count),
    .debug_capture_i (debug_capture),
    .rd_chk_i        (rd_chk),
    .dbg_chk_i       (dbg_chk),
    .error_count_o   (err_cnt)
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // inputs change 1 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic load_weights(input bit positive);
    logic [31:0] r;
    for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
      r        = next_rand();
      wgt_wr   = 1'b1;
      wgt_idx  = k;
      wgt_data = positive ? gat_pkg::feat_t'({1'b0, r[22:17], 1'b1}) : r[23:16];
      step();
    end
    wgt_wr = 1'b0;
    step();
  endtask

  task automatic send_node(input logic [`GAT_ADDR_W-1:0] addr, input int n_edges,
                           input bit positive, input bit gaps);
    logic [31:0] r;
    for (int e = 0; e < n_edges; e++) begin
      r = next_rand();
      for (int k = 0; k < `GAT_NUM_FEAT; k++) begin
        edge_feat[k] = positive ? gat_pkg::feat_t'({1'b0, r[k*8 +: 7]}) : r[k*8 +: 8];
      end
      edge_vld  = 1'b1;
      node_addr = addr;
      edge_last = (e == n_edges - 1);
      step();
      sent_edges++;
    end
    edge_vld  = 1'b0;
    edge_last = 1'b0;
    read_list.push_back(addr);
    r = next_rand();
    if (gaps && r[30]) begin
      step();
    end
  endtask

  task automatic send_random_nodes(input int n_nodes, input bit positive);
    logic [31:0] r;
    for (int n = 0; n < n_nodes; n++) begin
      r = next_rand();
      send_node((r >> 8) % `GAT_ADDR_LIMIT, 1 + (r >> 20) % 5, positive, 1'b1);
    end
  endtask

  // the activated edge count tells when the last edge has left the activation stage
  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (debug_count !== sent_edges && cycles < DRAIN_LIMIT) begin
      step();
      cycles++;
    end
    if (debug_count !== sent_edges) begin
      $display("timeout: pipeline did not drain, %0d of %0d edges counted",
               debug_count, sent_edges);
      timed_out = 1'b1;
    end else begin
      repeat (3) step();
    end
  endtask

  task automatic read_back();
    while (read_list.size() > 0) begin
      rd_addr = read_list.pop_front();
      rd_chk  = 1'b1;
      step();
    end
    rd_chk = 1'b0;
    repeat (2) step();
  endtask

  task automatic check_debug();
    dbg_chk = 1'b1;
    step();
    dbg_chk = 1'b0;
    step();
  endtask

  task automatic drain_and_check();
    wait_drain();
    if (!timed_out) begin
      read_back();
      check_debug();
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    tests_run++;
    if (timed_out) begin
      $display("test %s: aborted after a timeout", name);
      tests_failed++;
    end else if (err_cnt != errs_at_start) begin
      $display("test %s: %0d errors", name, err_cnt - errs_at_start);
      tests_failed++;
    end else begin
      $display("test %s: ok", name);
    end
  endtask

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    wgt_wr     = 1'b0;
    wgt_idx    = '0;
    wgt_data   = '0;
    edge_vld   = 1'b0;
    edge_feat  = '0;
    node_addr  = '0;
    edge_last  = 1'b0;
    rd_addr    = '0;
    rd_chk     = 1'b0;
    dbg_chk    = 1'b0;
    rng_state  = 32'h8f225dab;
    timed_out  = 1'b0;
    sent_edges = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    step();

    err_before = err_cnt;
    check_debug();
    report_test("reset_state", err_before);

    err_before = err_cnt;
    load_weights(1'b1);
    send_random_nodes(12, 1'b1);
    drain_and_check();
    report_test("positive_nodes", err_before);

    if (!timed_out) begin
      err_before = err_cnt;
      load_weights(1'b0);
      send_random_nodes(12, 1'b0);
      drain_and_check();
      report_test("mixed_sign", err_before);
    end

    // count and flags after all traffic so far, bit 3 still clear
    if (!timed_out) begin
      err_before = err_cnt;
      check_debug();
      report_test("debug_counters", err_before);
    end

    if (!timed_out) begin
      err_before = err_cnt;
      send_node(`GAT_CAPTURE_NODE, 3, 1'b0, 1'b0);
      send_node(50, 2, 1'b0, 1'b0);
      send_node(`GAT_CAPTURE_NODE, 2, 1'b0, 1'b1);
      send_node(5, 1, 1'b0, 1'b0);
      drain_and_check();
      report_test("limit_and_capture", err_before);
    end

    // one single-edge node per cycle keeps every stage busy
    if (!timed_out) begin
      err_before = err_cnt;
      for (int n = 16; n < 40; n++) begin
        send_node(n, 1, 1'b0, 1'b0);
      end
      drain_and_check();
      report_test("back_to_back", err_before);
    end

    $display("tests run: %0d, tests failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
    if (!timed_out && tests_failed == 0 && err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
